//--- hdl/lc4_params.svh
`ifndef LC4_PARAMS_SVH
`define LC4_PARAMS_SVH

// data and address width
`define LC4_WORD 16

// architectural registers r0 to r7
`define LC4_REGS 8

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// opcode field bounds in the instruction word
`define LC4_OPC_HI 15
`define LC4_OPC_LO 12

`endif

//--- hdl/lc4_pkg.sv
`default_nettype none

`include "lc4_params.svh"

package lc4_pkg;

   typedef logic [`LC4_WORD-1:0] word_t;
   typedef logic [`LC4_WORD-1:0] insn_t;
   typedef logic [$clog2(`LC4_REGS)-1:0] rsel_t;
   // one-hot n, z, p
   typedef logic [2:0] nzp_t;

   // only the opcodes of the supported subset
   typedef enum logic [`LC4_OPC_HI-`LC4_OPC_LO:0] {
      OPC_BR    = 4'b0000,
      OPC_ARITH = 4'b0001,
      OPC_AND   = 4'b0101,
      OPC_LDR   = 4'b0110,
      OPC_STR   = 4'b0111,
      OPC_CONST = 4'b1001
   } opcode_t;

   // stall code carried by every slot down to the commit trace
   typedef enum logic [1:0] {
      STALL_NONE   = 2'd0,
      STALL_DATA   = 2'd1,
      STALL_BRANCH = 2'd2,
      STALL_LOAD   = 2'd3
   } stall_t;

   typedef struct packed {
      rsel_t   rs_sel;
      rsel_t   rt_sel;
      rsel_t   rd_sel;
      logic    regfile_we;
      logic    nzp_we;
      logic    is_load;
      logic    is_store;
      logic    is_branch;
      opcode_t opcode;
   } ctl_t;

   typedef struct packed {
      stall_t stall;
      word_t  pc;
      insn_t  insn;
      ctl_t   ctl;
      word_t  rs_data;
      word_t  rt_data;
   } uop_t;

   // writeback trace record, one per cycle
   typedef struct packed {
      stall_t stall;
      word_t  pc;
      insn_t  insn;
      logic   regfile_we;
      rsel_t  wsel;
      word_t  wdata;
      logic   nzp_we;
      nzp_t   nzp_bits;
      logic   dmem_we;
      word_t  dmem_addr;
      word_t  dmem_data;
   } commit_t;

endpackage

`default_nettype wire

//--- hdl/lc4_regfile.sv
`default_nettype none

`include "lc4_params.svh"

module lc4_regfile import lc4_pkg::*; (
   input  wire        gwe,
   input  wire        i_reset,
   input  wire rsel_t i_rs_sel,
   input  wire rsel_t i_rt_sel,
   output word_t      o_rs_data,
   output word_t      o_rt_data,
   input  wire rsel_t i_wsel,
   input  wire        i_we,
   input  wire word_t i_wdata
);

   word_t regs [`LC4_REGS];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < `LC4_REGS; i++)
            regs[i] <= '0;
      end else if (i_we) begin
         regs[i_wsel] <= i_wdata;
      end
   end

   // bypass the value being written this cycle
   assign o_rs_data = (i_we && (i_wsel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = (i_we && (i_wsel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

`default_nettype wire

//--- hdl/lc4_fetch.sv
`default_nettype none

`include "lc4_params.svh"

module lc4_fetch import lc4_pkg::*; (
   input  wire        gwe,
   input  wire        i_reset,
   input  wire        i_hold,
   input  wire        i_redirect,
   input  wire word_t i_target,
   input  wire insn_t i_imem_data,
   output word_t      o_imem_addr,
   output uop_t       o_dec_slot
);

   word_t pc_q;
   uop_t  slot_q;
   uop_t  fetched;

   // operands are filled in by decode
   always_comb begin
      fetched = '0;
      fetched.stall = STALL_NONE;
      fetched.pc = pc_q;
      fetched.insn = i_imem_data;
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc_q <= `LC4_RESET_PC;
         slot_q <= '0;
      end else if (i_redirect) begin
         // redirect wins over hold, wrong-path fetch is dropped
         pc_q <= i_target;
         slot_q <= '{stall: STALL_BRANCH, default: '0};
      end else if (!i_hold) begin
         pc_q <= pc_q + word_t'(1);
         slot_q <= fetched;
      end
   end

   assign o_imem_addr = pc_q;
   assign o_dec_slot = slot_q;

endmodule

`default_nettype wire

//--- hdl/lc4_control.sv
`default_nettype none

`include "lc4_params.svh"

module lc4_control import lc4_pkg::*; (
   input  wire        gwe,
   input  wire        i_reset,
   input  wire uop_t  i_dec_slot,
   input  wire        i_redirect,
   input  wire ctl_t  i_ex_ctl,
   input  wire ctl_t  i_mem_ctl,
   input  wire word_t i_rs_data,
   input  wire word_t i_rt_data,
   output rsel_t      o_rs_sel,
   output rsel_t      o_rt_sel,
   output logic       o_hold,
   output uop_t       o_ex_uop
);

   insn_t  insn;
   ctl_t   ctl;
   logic   uses_rs;
   logic   uses_rt;
   logic   ex_hit;
   logic   mem_hit;
   logic   data_stall;
   logic   br_stall;
   logic   issue_bubble;
   stall_t bubble_code;
   // decode slot and execute slot hold bubbles, not real instructions
   logic   dec_bubble_q;
   logic   ex_bubble_q;

   // true when an older producer writes one of the consumer's sources
   function automatic logic src_hit(ctl_t prod, ctl_t cons, logic rs_used, logic rt_used);
      return prod.regfile_we &
             ((rs_used & (prod.rd_sel == cons.rs_sel)) |
              (rt_used & (prod.rd_sel == cons.rt_sel)));
   endfunction

   assign insn = i_dec_slot.insn;

   // instruction decode
   always_comb begin
      ctl = '0;
      ctl.opcode = opcode_t'(insn[`LC4_OPC_HI:`LC4_OPC_LO]);
      ctl.rs_sel = insn[8:6];
      ctl.rt_sel = insn[2:0];
      ctl.rd_sel = insn[11:9];
      uses_rs = 1'b0;
      uses_rt = 1'b0;
      case (ctl.opcode)
         OPC_ARITH, OPC_AND: begin
            ctl.regfile_we = 1'b1;
            ctl.nzp_we = 1'b1;
            uses_rs = 1'b1;
            // bit 5 set means imm5 instead of rt
            uses_rt = ~insn[5];
         end
         OPC_CONST: begin
            ctl.regfile_we = 1'b1;
            ctl.nzp_we = 1'b1;
         end
         OPC_LDR: begin
            ctl.regfile_we = 1'b1;
            ctl.nzp_we = 1'b1;
            ctl.is_load = 1'b1;
            uses_rs = 1'b1;
         end
         OPC_STR: begin
            ctl.is_store = 1'b1;
            // store data register sits in the rd field
            ctl.rt_sel = insn[11:9];
            uses_rs = 1'b1;
            uses_rt = 1'b1;
         end
         OPC_BR: begin
            ctl.is_branch = 1'b1;
         end
         default: ;
      endcase
   end

   assign o_rs_sel = ctl.rs_sel;
   assign o_rt_sel = ctl.rt_sel;

   // interlocks against execute and memory, writeback is covered by write-through
   assign ex_hit = src_hit(i_ex_ctl, ctl, uses_rs, uses_rt);
   assign mem_hit = src_hit(i_mem_ctl, ctl, uses_rs, uses_rt);
   assign data_stall = ~dec_bubble_q & (ex_hit | mem_hit);
   // branch waits until nzp is settled in the register
   assign br_stall = ~dec_bubble_q & ctl.is_branch & (i_ex_ctl.nzp_we | i_mem_ctl.nzp_we);
   assign o_hold = data_stall | br_stall;

   assign issue_bubble = i_redirect | dec_bubble_q | o_hold;

   // load code only when the load is the nearest real instruction ahead
   always_comb begin
      if (i_redirect)
         bubble_code = STALL_BRANCH;
      else if (dec_bubble_q)
         bubble_code = i_dec_slot.stall;
      else if (ex_hit)
         bubble_code = i_ex_ctl.is_load ? STALL_LOAD : STALL_DATA;
      else if (mem_hit && i_mem_ctl.is_load && ex_bubble_q)
         bubble_code = STALL_LOAD;
      else
         bubble_code = STALL_DATA;
   end

   always_comb begin
      o_ex_uop = '0;
      if (issue_bubble) begin
         o_ex_uop.stall = bubble_code;
      end else begin
         o_ex_uop.stall = STALL_NONE;
         o_ex_uop.pc = i_dec_slot.pc;
         o_ex_uop.insn = insn;
         o_ex_uop.ctl = ctl;
         o_ex_uop.rs_data = i_rs_data;
         o_ex_uop.rt_data = i_rt_data;
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         dec_bubble_q <= 1'b1;
         ex_bubble_q <= 1'b1;
      end else begin
         ex_bubble_q <= issue_bubble;
         // fetch squashes its slot on redirect and keeps it on hold
         if (i_redirect)
            dec_bubble_q <= 1'b1;
         else if (!o_hold)
            dec_bubble_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- hdl/lc4_execute.sv
`default_nettype none

module lc4_execute import lc4_pkg::*; (
   input  wire        gwe,
   input  wire        i_reset,
   input  wire uop_t  i_uop,
   input  wire nzp_t  i_nzp,
   output ctl_t       o_ctl,
   output uop_t       o_uop,
   output word_t      o_result,
   output logic       o_redirect,
   output word_t      o_target
);

   uop_t  uop_q;
   insn_t insn;
   word_t imm5;
   word_t imm6;
   word_t imm9;
   word_t rs;
   word_t rt;
   word_t result;

   // decode/execute register
   always_ff @(posedge gwe) begin
      if (i_reset)
         uop_q <= '0;
      else
         uop_q <= i_uop;
   end

   assign insn = uop_q.insn;
   assign rs = uop_q.rs_data;
   assign rt = uop_q.rt_data;

   // sign-extended immediates
   assign imm5 = word_t'($signed(insn[4:0]));
   assign imm6 = word_t'($signed(insn[5:0]));
   assign imm9 = word_t'($signed(insn[8:0]));

   always_comb begin
      case (uop_q.ctl.opcode)
         OPC_ARITH: begin
            if (insn[5])
               result = rs + imm5;
            else if (insn[4:3] == 2'b10)
               result = rs - rt;
            else
               result = rs + rt;
         end
         OPC_AND:   result = rs & rt;
         OPC_CONST: result = imm9;
         // effective address for loads and stores
         OPC_LDR, OPC_STR: result = rs + imm6;
         default:   result = '0;
      endcase
   end

   // taken when any requested condition bit matches the current nzp
   assign o_redirect = uop_q.ctl.is_branch & (|(insn[11:9] & i_nzp));
   assign o_target = uop_q.pc + word_t'(1) + imm9;

   assign o_ctl = uop_q.ctl;
   assign o_uop = uop_q;
   assign o_result = result;

endmodule

`default_nettype wire

//--- hdl/lc4_memwb.sv
`default_nettype none

`include "lc4_params.svh"

module lc4_memwb import lc4_pkg::*; (
   input  wire        gwe,
   input  wire        i_reset,
   input  wire uop_t  i_uop,
   input  wire word_t i_result,
   input  wire word_t i_dmem_rdata,
   output word_t      o_dmem_addr,
   output word_t      o_dmem_wdata,
   output logic       o_dmem_we,
   output ctl_t       o_ctl,
   output nzp_t       o_nzp,
   output rsel_t      o_rf_wsel,
   output logic       o_rf_we,
   output word_t      o_rf_wdata,
   output commit_t    o_commit
);

   uop_t    mem_q;
   word_t   mem_result_q;
   word_t   wdata;
   nzp_t    nzp_d;
   nzp_t    nzp_q;
   commit_t commit_d;
   commit_t commit_q;

   // data memory port, address only for loads and stores
   assign o_dmem_addr = (mem_q.ctl.is_load | mem_q.ctl.is_store) ? mem_result_q : '0;
   assign o_dmem_wdata = mem_q.rt_data;
   assign o_dmem_we = mem_q.ctl.is_store;

   assign wdata = mem_q.ctl.is_load ? i_dmem_rdata : mem_result_q;

   // condition bits from the value headed for the regfile
   always_comb begin
      if (wdata == '0)
         nzp_d = 3'b010;
      else if (wdata[`LC4_WORD-1])
         nzp_d = 3'b100;
      else
         nzp_d = 3'b001;
   end

   always_comb begin
      commit_d.stall = mem_q.stall;
      commit_d.pc = mem_q.pc;
      commit_d.insn = mem_q.insn;
      commit_d.regfile_we = mem_q.ctl.regfile_we;
      commit_d.wsel = mem_q.ctl.rd_sel;
      commit_d.wdata = wdata;
      commit_d.nzp_we = mem_q.ctl.nzp_we;
      commit_d.nzp_bits = mem_q.ctl.nzp_we ? nzp_d : '0;
      commit_d.dmem_we = o_dmem_we;
      commit_d.dmem_addr = o_dmem_addr;
      // loaded value or stored rt
      commit_d.dmem_data = mem_q.ctl.is_load  ? i_dmem_rdata :
                           mem_q.ctl.is_store ? mem_q.rt_data : '0;
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         mem_q <= '0;
         mem_result_q <= '0;
         commit_q <= '0;
         nzp_q <= '0;
      end else begin
         mem_q <= i_uop;
         mem_result_q <= i_result;
         commit_q <= commit_d;
         // nzp updates as the slot enters writeback
         if (mem_q.ctl.nzp_we)
            nzp_q <= nzp_d;
      end
   end

   assign o_ctl = mem_q.ctl;
   assign o_nzp = nzp_q;
   // writeback drives the regfile from the commit record
   assign o_rf_wsel = commit_q.wsel;
   assign o_rf_we = commit_q.regfile_we;
   assign o_rf_wdata = commit_q.wdata;
   assign o_commit = commit_q;

endmodule

`default_nettype wire

//--- hdl/lc4_core.sv
`default_nettype none

module lc4_core import lc4_pkg::*; (
   input  wire        gwe,
   input  wire        i_reset,
   output word_t      o_imem_addr,
   input  wire insn_t i_imem_data,
   output word_t      o_dmem_addr,
   output word_t      o_dmem_wdata,
   output logic       o_dmem_we,
   input  wire word_t i_dmem_rdata,
   output commit_t    o_commit
);

   uop_t  dec_slot;
   uop_t  issue_uop;
   uop_t  ex_uop;
   ctl_t  ex_ctl;
   ctl_t  mem_ctl;
   rsel_t rs_sel;
   rsel_t rt_sel;
   rsel_t rf_wsel;
   word_t rs_data;
   word_t rt_data;
   word_t rf_wdata;
   word_t ex_result;
   word_t target;
   nzp_t  nzp;
   logic  hold;
   logic  redirect;
   logic  rf_we;

   // fetch stage and fetch/decode register
   lc4_fetch u_fetch (
      .gwe         (gwe),
      .i_reset     (i_reset),
      .i_hold      (hold),
      .i_redirect  (redirect),
      .i_target    (target),
      .i_imem_data (i_imem_data),
      .o_imem_addr (o_imem_addr),
      .o_dec_slot  (dec_slot)
   );

   // decode, interlock and squash
   lc4_control u_control (
      .gwe        (gwe),
      .i_reset    (i_reset),
      .i_dec_slot (dec_slot),
      .i_redirect (redirect),
      .i_ex_ctl   (ex_ctl),
      .i_mem_ctl  (mem_ctl),
      .i_rs_data  (rs_data),
      .i_rt_data  (rt_data),
      .o_rs_sel   (rs_sel),
      .o_rt_sel   (rt_sel),
      .o_hold     (hold),
      .o_ex_uop   (issue_uop)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_rs_sel  (rs_sel),
      .i_rt_sel  (rt_sel),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_wsel    (rf_wsel),
      .i_we      (rf_we),
      .i_wdata   (rf_wdata)
   );

   // branch resolves here
   lc4_execute u_execute (
      .gwe        (gwe),
      .i_reset    (i_reset),
      .i_uop      (issue_uop),
      .i_nzp      (nzp),
      .o_ctl      (ex_ctl),
      .o_uop      (ex_uop),
      .o_result   (ex_result),
      .o_redirect (redirect),
      .o_target   (target)
   );

   lc4_memwb u_memwb (
      .gwe          (gwe),
      .i_reset      (i_reset),
      .i_uop        (ex_uop),
      .i_result     (ex_result),
      .i_dmem_rdata (i_dmem_rdata),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_wdata (o_dmem_wdata),
      .o_dmem_we    (o_dmem_we),
      .o_ctl        (mem_ctl),
      .o_nzp        (nzp),
      .o_rf_wsel    (rf_wsel),
      .o_rf_we      (rf_we),
      .o_rf_wdata   (rf_wdata),
      .o_commit     (o_commit)
   );

endmodule

`default_nettype wire

//--- test/lc4_sva.sv
`default_nettype none

module lc4_sva import lc4_pkg::*; (
   input wire          gwe,
   input wire          i_reset,
   input wire commit_t i_commit,
   input wire          i_dmem_we,
   input wire          i_hold,
   input wire          i_redirect,
   input wire word_t   i_pc
);
   timeunit 1ns;
   timeprecision 1ps;

   // a bubble leaving writeback touches neither regfile, nzp nor memory
   a_bubble_quiet: assert property (@(posedge gwe) disable iff (i_reset)
      i_commit.stall != STALL_NONE |->
         !(i_commit.regfile_we || i_commit.nzp_we || i_commit.dmem_we))
      else $error("bubble commit with an enable set");

   // no store during reset or in the first cycle after it
   a_reset_no_store: assert property (@(posedge gwe)
      (i_reset || $past(i_reset)) |=> !i_dmem_we)
      else $error("data memory write during or right after reset");

   // held fetch keeps its pc unless a branch redirects it
   a_hold_keeps_pc: assert property (@(posedge gwe) disable iff (i_reset)
      i_hold && !i_redirect |=> $stable(i_pc))
      else $error("pc moved while fetch was held");

endmodule

bind lc4_core lc4_sva u_sva (
   .gwe        (gwe),
   .i_reset    (i_reset),
   .i_commit   (o_commit),
   .i_dmem_we  (o_dmem_we),
   .i_hold     (hold),
   .i_redirect (redirect),
   .i_pc       (o_imem_addr)
);

`default_nettype wire

//--- test/lc4_tb.sv
`default_nettype none

`include "lc4_params.svh"

module lc4_tb import lc4_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] SEED = 32'hf21049f1;
   localparam int PROG_LEN = 64;
   localparam word_t PROG_BASE = `LC4_RESET_PC;
   localparam word_t PROG_END = PROG_BASE + word_t'(PROG_LEN);
   // worst case is well under four cycles per instruction plus pipeline fill
   localparam int TIMEOUT = PROG_LEN * 4 + 40;
   localparam word_t FILL_KEY = 16'h3c5a;

   logic    gwe;
   logic    reset;
   word_t   imem_addr;
   insn_t   imem_data;
   word_t   dmem_addr;
   word_t   dmem_wdata;
   logic    dmem_we;
   word_t   dmem_rdata;
   commit_t commit;

   // instruction memory, data memory seen by the DUT, and the model's own copy
   word_t imem [65536];
   word_t dmem [65536];
   word_t ref_mem [65536];

   // architectural model state
   word_t regs [`LC4_REGS];
   nzp_t  nzp;
   word_t model_pc;
   int    branch_left;
   logic  last_was_load;
   logic  done;
   logic [31:0] lfsr;
   int    cycles = 0;

   lc4_core uut (
      .gwe          (gwe),
      .i_reset      (reset),
      .o_imem_addr  (imem_addr),
      .i_imem_data  (imem_data),
      .o_dmem_addr  (dmem_addr),
      .o_dmem_wdata (dmem_wdata),
      .o_dmem_we    (dmem_we),
      .i_dmem_rdata (dmem_rdata),
      .o_commit     (commit)
   );

   initial begin
      gwe = 1'b0;
      forever #10 gwe = ~gwe;
   end

   task automatic fail_run();
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   always @(posedge gwe) begin
      if (!reset) begin
         cycles = cycles + 1;
         if (cycles > TIMEOUT) begin
            $display("timeout: program end not reached within %0d cycles", TIMEOUT);
            fail_run();
         end
      end
   end

   // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h80200003;
      return s >> 1;
   endfunction

   // one lfsr step per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic word_t sext(input word_t v, input int bits);
      word_t m;
      m = word_t'(1) << (bits - 1);
      v = v & ((m << 1) - word_t'(1));
      return (v ^ m) - m;
   endfunction

   // sign of a written value as one-hot n, z, p
   function automatic nzp_t nzp_of(input word_t v);
      if (v == '0)
         return 3'b010;
      if (v[15])
         return 3'b100;
      return 3'b001;
   endfunction

   task automatic load_memories();
      for (int a = 0; a < 65536; a++) begin
         // all-zero word is BR with nzp 000, a NOP
         imem[a] = '0;
         dmem[a] = word_t'(a) ^ FILL_KEY;
         ref_mem[a] = word_t'(a) ^ FILL_KEY;
      end
   endtask

   task automatic build_program();
      logic [2:0]  kind;
      rsel_t       rd;
      rsel_t       rs;
      rsel_t       rt;
      logic [15:0] r;
      logic [15:0] cond;
      insn_t       insn;
      for (int i = 0; i < PROG_LEN; i++) begin
         kind = 3'(rand_bits(3));
         // r7 is never written, so it stays zero as the load/store base
         rd = rsel_t'(rand_bits(3) % 16'd7);
         rs = rsel_t'(rand_bits(3));
         rt = rsel_t'(rand_bits(3));
         case (kind)
            3'd0: insn = {4'b0001, rd, rs, 3'b000, rt};
            3'd1: insn = {4'b0001, rd, rs, 3'b010, rt};
            3'd2: insn = {4'b0101, rd, rs, 3'b000, rt};
            3'd3: begin
               r = rand_bits(5);
               insn = {4'b0001, rd, rs, 1'b1, r[4:0]};
            end
            3'd4: begin
               r = rand_bits(9);
               insn = {4'b1001, rd, r[8:0]};
            end
            3'd5: begin
               // offsets -4 to 3 so loads often meet earlier stores
               r = rand_bits(3);
               insn = {4'b0110, rd, 3'd7, {3{r[2]}}, r[2:0]};
            end
            3'd6: begin
               r = rand_bits(3);
               insn = {4'b0111, rt, 3'd7, {3{r[2]}}, r[2:0]};
            end
            3'd7: begin
               // forward only, offset 0 to 3
               cond = rand_bits(3);
               r = rand_bits(2);
               insn = {4'b0000, cond[2:0], 7'd0, r[1:0]};
            end
         endcase
         imem[PROG_BASE + word_t'(i)] = insn;
      end
   endtask

   // combinational memories answered at the falling edge
   task automatic serve_memories();
      imem_data = imem[imem_addr];
      dmem_rdata = dmem[dmem_addr];
      // store lands before the next access
      if (dmem_we)
         dmem[dmem_addr] = dmem_wdata;
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_sel(input string name, input rsel_t got, input rsel_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_nzp(input string name, input nzp_t got, input nzp_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_stall(input string name, input stall_t got, input stall_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   // execute one instruction in the model and compare its commit
   task automatic retire_model(input commit_t c);
      insn_t insn;
      word_t rs;
      word_t rt;
      word_t val;
      word_t addr;
      word_t next_pc;
      logic  we;
      logic  is_ld;
      logic  is_st;
      insn = imem[model_pc];
      rs = regs[insn[8:6]];
      rt = regs[insn[2:0]];
      val = '0;
      addr = '0;
      we = 1'b0;
      is_ld = 1'b0;
      is_st = 1'b0;
      next_pc = model_pc + word_t'(1);
      check_word("o_commit.pc", c.pc, model_pc);
      check_word("o_commit.insn", c.insn, insn);
      case (insn[15:12])
         4'b0001: begin
            we = 1'b1;
            if (insn[5])
               val = rs + sext(word_t'(insn[4:0]), 5);
            else if (insn[5:3] == 3'b010)
               val = rs - rt;
            else
               val = rs + rt;
         end
         4'b0101: begin
            we = 1'b1;
            val = rs & rt;
         end
         4'b1001: begin
            we = 1'b1;
            val = sext(word_t'(insn[8:0]), 9);
         end
         4'b0110: begin
            we = 1'b1;
            is_ld = 1'b1;
            addr = rs + sext(word_t'(insn[5:0]), 6);
            val = ref_mem[addr];
         end
         4'b0111: begin
            is_st = 1'b1;
            addr = rs + sext(word_t'(insn[5:0]), 6);
            // store data comes from the rd field register
            val = regs[insn[11:9]];
         end
         4'b0000: begin
            if (|(insn[11:9] & nzp)) begin
               next_pc = model_pc + word_t'(1) + sext(word_t'(insn[8:0]), 9);
               branch_left = 2;
            end
         end
         default: begin
            $display("commit of an opcode that the program never contains");
            fail_run();
         end
      endcase
      check_bit("o_commit.regfile_we", c.regfile_we, we);
      check_bit("o_commit.nzp_we", c.nzp_we, we);
      if (we) begin
         check_sel("o_commit.wsel", c.wsel, rsel_t'(insn[11:9]));
         check_word("o_commit.wdata", c.wdata, val);
         check_nzp("o_commit.nzp_bits", c.nzp_bits, nzp_of(val));
         regs[insn[11:9]] = val;
         nzp = nzp_of(val);
      end
      check_bit("o_commit.dmem_we", c.dmem_we, is_st);
      if (is_ld || is_st) begin
         check_word("o_commit.dmem_addr", c.dmem_addr, addr);
         check_word("o_commit.dmem_data", c.dmem_data, val);
      end
      if (is_st) begin
         // the store went out on the memory port one cycle before its commit
         check_word("o_dmem_wdata", dmem[addr], val);
         ref_mem[addr] = val;
      end
      last_was_load = is_ld;
      model_pc = next_pc;
      if (model_pc >= PROG_END)
         done = 1'b1;
   endtask

   task automatic score_commit();
      commit_t c;
      c = commit;
      if (branch_left > 0) begin
         // squashed slots behind a taken branch
         check_stall("o_commit.stall", c.stall, STALL_BRANCH);
         branch_left = branch_left - 1;
      end else if (c.stall == STALL_BRANCH) begin
         $display("branch bubble committed without a taken branch ahead of it");
         fail_run();
      end else if (c.stall == STALL_LOAD && !last_was_load) begin
         $display("load stall bubble while the last committed instruction is no load");
         fail_run();
      end else if (c.stall == STALL_NONE) begin
         retire_model(c);
      end
   endtask

   initial begin
      reset = 1'b1;
      imem_data = '0;
      dmem_rdata = '0;
      lfsr = SEED;
      nzp = '0;
      model_pc = PROG_BASE;
      branch_left = 0;
      last_was_load = 1'b0;
      done = 1'b0;
      for (int i = 0; i < `LC4_REGS; i++)
         regs[i] = '0;
      load_memories();
      build_program();

      repeat (8) @(posedge gwe);
      @(negedge gwe);
      reset = 1'b0;
      serve_memories();

      // three fill bubbles ahead of the first fetched instruction
      repeat (3) begin
         @(negedge gwe);
         serve_memories();
      end
      @(negedge gwe);
      if (commit.stall !== STALL_NONE) begin
         $display("first commit after reset is a bubble, not the reset pc");
         fail_run();
      end
      score_commit();
      serve_memories();

      while (!done) begin
         @(negedge gwe);
         score_commit();
         serve_memories();
      end

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/lc4_pkg.sv
hdl/lc4_regfile.sv
hdl/lc4_fetch.sv
hdl/lc4_control.sv
hdl/lc4_execute.sv
hdl/lc4_memwb.sv
hdl/lc4_core.sv
test/lc4_sva.sv
test/lc4_tb.sv

//--- Makefile
BIN := obj_dir/Vlc4_tb
SRCS := $(shell grep -v '^+' all.f) hdl/lc4_params.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): all.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module lc4_tb -f all.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
